//--- cache.f
verilog/cache_pkg.sv
verilog/line_ram.sv
verilog/cache_ways.sv
verilog/lru_policy.sv
verilog/cache_datapath.sv
verilog/cache_ctrl.sv
verilog/cache.sv
sim/tb_clock.sv
sim/tb_cache.sv

//--- sim/tb_cache.sv
module tb_cache import cache_pkg::*; ();

    localparam int LINE_WORDS     = 4;
    localparam int LINE_WIDTH     = WORD_WIDTH * LINE_WORDS;
    localparam int LINE_BYTES     = LINE_WORDS * 4;
    localparam int MEM_WORDS      = 1024;  // 4 KB
    localparam int MAX_LATENCY    = 4;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int DRIVE_DELAY    = 2;

    typedef struct packed {
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] wdata;
        logic [WORD_WIDTH-1:0] rdata;    // expected read word
        logic                  fetch;    // one line read expected
        logic                  wb;       // one write-back expected
        logic [ADDR_WIDTH-1:0] wb_addr;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  r_req;
    logic                  w_req;
    logic [WORD_WIDTH-1:0] w_data;
    logic [WORD_WIDTH-1:0] r_data;
    logic                  miss;
    logic                  resp_valid;
    logic                  mem_r;
    logic                  mem_w;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [LINE_WIDTH-1:0] mem_w_data;
    logic [LINE_WIDTH-1:0] mem_r_data;
    logic                  mem_ready;

    logic [WORD_WIDTH-1:0] mem_words [MEM_WORDS];
    logic                  log_write [$];  // 1 for a write-back, 0 for a fetch
    logic [ADDR_WIDTH-1:0] log_addr  [$];
    row_t                  rows      [$];
    integer                seed = 32'hffe8;

    tb_clock u_clock (.clk(clk), .rstn(rstn));

    cache #(.INDEX_WIDTH(3), .WORD_OFFSET_WIDTH(2), .WAY_NUM(2)) DUT (
        .clk(clk), .rstn(rstn), .addr(addr), .r_req(r_req), .w_req(w_req),
        .w_data(w_data), .r_data(r_data), .miss(miss), .resp_valid(resp_valid),
        .mem_r(mem_r), .mem_w(mem_w), .mem_addr(mem_addr), .mem_w_data(mem_w_data),
        .mem_r_data(mem_r_data), .mem_ready(mem_ready)
    );

    function automatic logic [WORD_WIDTH-1:0] init_word(input logic [ADDR_WIDTH-1:0] a);
        return {8'h5a, a[11:0], ~a[11:0]};  // unique per word of the 4 KB
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else stop_on_error(what);
    endtask

    task automatic add_row(input logic write, input logic [31:0] a, input logic [31:0] wd,
                           input logic [31:0] rd, input logic fetch, input logic wb,
                           input logic [31:0] wba);
        row_t r;
        r.write   = write;
        r.addr    = a;
        r.wdata   = wd;
        r.rdata   = rd;
        r.fetch   = fetch;
        r.wb      = wb;
        r.wb_addr = wba;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // set 2: cold read, read hit, write hit
        add_row(0, 32'h024, 0, init_word(32'h024), 1, 0, 0);
        add_row(0, 32'h02c, 0, init_word(32'h02c), 0, 0, 0);
        add_row(1, 32'h028, 32'h1234abcd, 0, 0, 0, 0);
        add_row(0, 32'h028, 0, 32'h1234abcd, 0, 0, 0);
        // set 3: write miss merges into the fetched line
        add_row(1, 32'h234, 32'hcafe0001, 0, 1, 0, 0);
        add_row(0, 32'h234, 0, 32'hcafe0001, 0, 0, 0);
        add_row(0, 32'h238, 0, init_word(32'h238), 0, 0, 0);
        // set 5: A B A C, then C has pushed out B
        add_row(0, 32'h050, 0, init_word(32'h050), 1, 0, 0);
        add_row(0, 32'h0d4, 0, init_word(32'h0d4), 1, 0, 0);
        add_row(0, 32'h058, 0, init_word(32'h058), 0, 0, 0);
        add_row(0, 32'h15c, 0, init_word(32'h15c), 1, 0, 0);
        add_row(0, 32'h054, 0, init_word(32'h054), 0, 0, 0);
        add_row(0, 32'h0d0, 0, init_word(32'h0d0), 1, 0, 0);
        // set 2: dirty line 0x020 goes back to memory
        add_row(0, 32'h0a0, 0, init_word(32'h0a0), 1, 0, 0);
        add_row(0, 32'h120, 0, init_word(32'h120), 1, 1, 32'h020);
        add_row(0, 32'h028, 0, 32'h1234abcd, 1, 0, 0);
        // set 3: two dirty lines evicted in turn
        add_row(1, 32'h2b0, 32'h0badf00d, 0, 1, 0, 0);
        add_row(0, 32'h330, 0, init_word(32'h330), 1, 1, 32'h230);
        add_row(0, 32'h234, 0, 32'hcafe0001, 1, 1, 32'h2b0);
        add_row(0, 32'h2b0, 0, 32'h0badf00d, 1, 0, 0);
        add_row(0, 32'h238, 0, init_word(32'h238), 0, 0, 0);
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (rstn !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_on_error("reset was never released");
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_row(input int n);
        row_t r;
        int   cycles;
        int   reads;
        int   writes;
        r = rows[n];
        log_write.delete();
        log_addr.delete();
        addr   = r.addr;
        w_data = r.wdata;
        r_req  = !r.write;
        w_req  = r.write;
        cycles = 0;
        @(negedge clk);
        while (!resp_valid) begin
            compare_value("miss", miss, cycles > 0);  // low only in the capture cycle
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_error($sformatf("row %0d never got resp_valid", n));
            end
            @(negedge clk);
        end
        compare_value("miss", miss, 0);
        if (!r.write) begin
            compare_value("r_data", r_data, r.rdata);
        end
        reads  = 0;
        writes = 0;
        foreach (log_write[i]) begin
            if (log_write[i]) begin
                writes++;
            end else begin
                reads++;
            end
        end
        require(reads == int'(r.fetch),
                $sformatf("row %0d expected %0d line fetches but saw %0d", n, r.fetch, reads));
        require(writes == int'(r.wb),
                $sformatf("row %0d expected %0d write-backs but saw %0d", n, r.wb, writes));
        if (r.wb) begin
            require(log_write[0], $sformatf("row %0d fetched before writing back", n));
            compare_value("mem_addr", log_addr[0], r.wb_addr);
        end
        if (r.fetch) begin
            compare_value("mem_addr", log_addr[log_addr.size() - 1],
                          r.addr & ~ADDR_WIDTH'(LINE_BYTES - 1));
        end else if (!r.wb) begin
            require(cycles == 1, $sformatf("row %0d hit took %0d cycles", n, cycles));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        r_req = 1'b0;
        w_req = 1'b0;
    endtask

    // line memory, answers after 1 to 4 cycles
    initial begin : memory_model
        int delay;
        int base;
        mem_ready  = 1'b0;
        mem_r_data = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = init_word(ADDR_WIDTH'(i) << 2);
        end
        forever begin
            @(negedge clk);
            if (rstn && (mem_r || mem_w)) begin
                delay = 1 + ({$random(seed)} % MAX_LATENCY);
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                base = int'(mem_addr[11:2]);  // wraps at 4 KB
                log_write.push_back(mem_w);
                log_addr.push_back(mem_addr);
                for (int i = 0; i < LINE_WORDS; i++) begin
                    if (mem_w) begin
                        mem_words[base + i] = mem_w_data[i*WORD_WIDTH +: WORD_WIDTH];
                    end else begin
                        mem_r_data[i*WORD_WIDTH +: WORD_WIDTH] = mem_words[base + i];
                    end
                end
                mem_ready = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                mem_ready = 1'b0;
            end
        end
    end

    initial begin : stimulus
        addr   = '0;
        r_req  = 1'b0;
        w_req  = 1'b0;
        w_data = '0;
        build_table();
        wait_for_reset();
        compare_value("miss", miss, 0);
        compare_value("resp_valid", resp_valid, 0);
        compare_value("mem_r", mem_r, 0);
        compare_value("mem_w", mem_w, 0);
        foreach (rows[n]) begin
            apply_row(n);
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;  // period 40
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstn = 1'b1;  // released clear of the edge
    end

endmodule

//--- verilog/cache.sv
module cache import cache_pkg::*; #(
    parameter int  INDEX_WIDTH       = 3,
    parameter int  WORD_OFFSET_WIDTH = 2,
    parameter int  WAY_NUM           = 2,
    localparam int LINE_WIDTH        = WORD_WIDTH << WORD_OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  r_req,
    input  logic                  w_req,
    input  logic [WORD_WIDTH-1:0] w_data,
    output logic [WORD_WIDTH-1:0] r_data,
    output logic                  miss,        // cpu waits while high
    output logic                  resp_valid,  // one cycle per completed request
    output logic                  mem_r,
    output logic                  mem_w,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [LINE_WIDTH-1:0] mem_w_data,
    input  logic [LINE_WIDTH-1:0] mem_r_data,
    input  logic                  mem_ready
);

    localparam int WAY_WIDTH = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;
    localparam int INDEX_LSB = WORD_OFFSET_WIDTH + BYTE_OFFSET_WIDTH;

    cache_state_t          state;
    logic                  req_capture;
    logic                  ret_capture;
    logic                  victim_capture;
    logic                  array_we;
    logic                  fill_sel;
    logic                  lru_touch;
    logic                  hit;
    logic                  victim_dirty;
    logic                  op_write;
    logic [WAY_WIDTH-1:0]  hit_way;
    logic [WAY_WIDTH-1:0]  victim_way;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [ADDR_WIDTH-1:0] victim_addr;
    logic [LINE_WIDTH-1:0] wr_line;
    logic [LINE_WIDTH-1:0] sel_line;

    cache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .r_req(r_req), .w_req(w_req),
        .hit(hit), .victim_dirty(victim_dirty), .mem_ready(mem_ready),
        .state(state), .req_capture(req_capture), .ret_capture(ret_capture),
        .victim_capture(victim_capture), .array_we(array_we), .fill_sel(fill_sel),
        .lru_touch(lru_touch), .miss(miss), .resp_valid(resp_valid),
        .mem_r(mem_r), .mem_w(mem_w)
    );

    cache_datapath #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_datapath (
        .clk(clk), .rstn(rstn), .state(state), .addr(addr),
        .r_req(r_req), .w_req(w_req), .w_data(w_data),
        .req_capture(req_capture), .ret_capture(ret_capture),
        .victim_capture(victim_capture), .fill_sel(fill_sel),
        .mem_r_data(mem_r_data), .sel_line(sel_line), .victim_addr(victim_addr),
        .req_addr(req_addr), .op_write(op_write), .wr_line(wr_line),
        .r_data(r_data), .mem_addr(mem_addr), .mem_w_data(mem_w_data)
    );

    cache_ways #(
        .INDEX_WIDTH(INDEX_WIDTH),
        .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH),
        .WAY_NUM(WAY_NUM)
    ) u_ways (
        .clk(clk), .rstn(rstn), .addr(addr), .req_addr(req_addr),
        .array_we(array_we), .op_write(op_write), .wr_line(wr_line),
        .victim_way(victim_way), .hit(hit), .hit_way(hit_way),
        .victim_dirty(victim_dirty), .sel_line(sel_line), .victim_addr(victim_addr)
    );

    lru_policy #(.INDEX_WIDTH(INDEX_WIDTH), .WAY_NUM(WAY_NUM)) u_lru (
        .clk(clk), .rstn(rstn),
        .req_addr(req_addr[INDEX_LSB+INDEX_WIDTH-1:INDEX_LSB]),  // set index only
        .lru_touch(lru_touch), .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way)
    );

endmodule

//--- verilog/cache_ctrl.sv
module cache_ctrl import cache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         r_req,
    input  logic         w_req,
    input  logic         hit,
    input  logic         victim_dirty,
    input  logic         mem_ready,
    output cache_state_t state,
    output logic         req_capture,
    output logic         ret_capture,
    output logic         victim_capture,
    output logic         array_we,
    output logic         fill_sel,
    output logic         lru_touch,
    output logic         miss,
    output logic         resp_valid,
    output logic         mem_r,
    output logic         mem_w
);

    cache_state_t next_state;
    logic         op_write_q;
    logic         req_pending;

    assign req_pending = r_req || w_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= ST_IDLE;
            op_write_q <= 1'b0;
        end else begin
            state <= next_state;
            if (req_capture) begin
                op_write_q <= w_req && !r_req;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (req_pending) begin
                    next_state = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    next_state = ST_IDLE;
                end else if (victim_dirty && !mem_ready) begin
                    next_state = ST_EVICT;
                end else begin
                    next_state = ST_FETCH;  // clean miss or write-back already accepted
                end
            end
            ST_EVICT: begin
                if (mem_ready) begin
                    next_state = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (mem_ready) begin
                    next_state = ST_REFILL;
                end
            end
            default: next_state = ST_IDLE;  // refill always finishes in one cycle
        endcase
    end

    always_comb begin
        req_capture    = 1'b0;
        ret_capture    = 1'b0;
        victim_capture = 1'b0;
        array_we       = 1'b0;
        fill_sel       = 1'b0;
        lru_touch      = 1'b0;
        miss           = 1'b0;
        resp_valid     = 1'b0;
        mem_r          = 1'b0;
        mem_w          = 1'b0;
        case (state)
            ST_IDLE: req_capture = req_pending;
            ST_LOOKUP: begin
                if (hit) begin
                    resp_valid = 1'b1;
                    lru_touch  = 1'b1;
                    array_we   = op_write_q;  // write hit stores merged line and dirty tag
                end else begin
                    miss = 1'b1;
                    if (victim_dirty) begin
                        mem_w          = 1'b1;
                        victim_capture = 1'b1;
                    end
                end
            end
            ST_EVICT: begin
                miss  = 1'b1;
                mem_w = 1'b1;
            end
            ST_FETCH: begin
                miss        = 1'b1;
                mem_r       = 1'b1;
                ret_capture = mem_ready;
            end
            ST_REFILL: begin
                array_we   = 1'b1;
                fill_sel   = 1'b1;
                lru_touch  = 1'b1;
                resp_valid = 1'b1;
            end
            default: ;
        endcase
    end

    a_mem_exclusive: assert property (
        @(posedge clk) disable iff (!rstn) !(mem_r && mem_w)
    );

    a_resp_not_miss: assert property (
        @(posedge clk) disable iff (!rstn) resp_valid |-> !miss
    );

    // memory request is held until the memory accepts it
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (mem_r || mem_w) && !mem_ready |=> $stable({mem_r, mem_w})
    );

endmodule

//--- verilog/cache_datapath.sv
module cache_datapath import cache_pkg::*; #(
    parameter int  WORD_OFFSET_WIDTH = 2,
    localparam int LINE_WIDTH        = WORD_WIDTH << WORD_OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  cache_state_t          state,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  r_req,
    input  logic                  w_req,
    input  logic [WORD_WIDTH-1:0] w_data,
    input  logic                  req_capture,
    input  logic                  ret_capture,
    input  logic                  victim_capture,
    input  logic                  fill_sel,        // use the returned line, not the array line
    input  logic [LINE_WIDTH-1:0] mem_r_data,
    input  logic [LINE_WIDTH-1:0] sel_line,
    input  logic [ADDR_WIDTH-1:0] victim_addr,
    output logic [ADDR_WIDTH-1:0] req_addr,
    output logic                  op_write,
    output logic [LINE_WIDTH-1:0] wr_line,
    output logic [WORD_WIDTH-1:0] r_data,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [LINE_WIDTH-1:0] mem_w_data
);

    localparam int LINE_LSB    = WORD_OFFSET_WIDTH + BYTE_OFFSET_WIDTH;
    localparam int SHIFT_WIDTH = WORD_OFFSET_WIDTH + $clog2(WORD_WIDTH);

    logic [WORD_WIDTH-1:0]        w_data_buf;
    logic [LINE_WIDTH-1:0]        ret_buf;
    logic [ADDR_WIDTH-1:0]        victim_addr_buf;
    logic [LINE_WIDTH-1:0]        victim_line_buf;
    logic [WORD_OFFSET_WIDTH-1:0] word_off;
    logic [SHIFT_WIDTH-1:0]       bit_shift;
    logic [LINE_WIDTH-1:0]        base_line;
    logic [LINE_WIDTH-1:0]        word_mask;
    logic [LINE_WIDTH-1:0]        word_line;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_addr <= '0;
            op_write <= 1'b0;
        end else if (req_capture) begin
            req_addr <= addr;
            op_write <= w_req && !r_req;  // read wins when both are raised
        end
    end

    always_ff @(posedge clk) begin
        if (req_capture) begin
            w_data_buf <= w_data;
        end
        if (ret_capture) begin
            ret_buf <= mem_r_data;
        end
        if (victim_capture) begin
            victim_addr_buf <= victim_addr;  // arrays move on, keep the victim for evict
            victim_line_buf <= sel_line;
        end
    end

    assign word_off  = req_addr[LINE_LSB-1:BYTE_OFFSET_WIDTH];
    assign bit_shift = {word_off, {$clog2(WORD_WIDTH){1'b0}}};  // word offset times word width
    assign base_line = fill_sel ? ret_buf : sel_line;
    assign word_mask = LINE_WIDTH'({WORD_WIDTH{1'b1}}) << bit_shift;
    assign word_line = LINE_WIDTH'(w_data_buf) << bit_shift;

    assign wr_line = op_write ? ((base_line & ~word_mask) | word_line) : base_line;
    assign r_data  = WORD_WIDTH'(base_line >> bit_shift);

    always_comb begin
        case (state)
            ST_LOOKUP: begin
                mem_addr   = victim_addr;  // write-back starts straight from the arrays
                mem_w_data = sel_line;
            end
            ST_EVICT: begin
                mem_addr   = victim_addr_buf;
                mem_w_data = victim_line_buf;
            end
            default: begin
                mem_addr   = {req_addr[ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};
                mem_w_data = victim_line_buf;  // don't care outside a write
            end
        endcase
    end

endmodule

//--- verilog/lru_policy.sv
module lru_policy #(
    parameter int  INDEX_WIDTH = 3,
    parameter int  WAY_NUM     = 2,
    localparam int WAY_WIDTH   = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [INDEX_WIDTH-1:0] req_addr,  // set index of the buffered request
    input  logic                   lru_touch,
    input  logic                   hit,
    input  logic [WAY_WIDTH-1:0]   hit_way,
    output logic [WAY_WIDTH-1:0]   victim_way
);

    localparam int SET_NUM = 1 << INDEX_WIDTH;

    logic [WAY_WIDTH-1:0] age [SET_NUM][WAY_NUM];  // 0 is least recently used
    logic [WAY_WIDTH-1:0] touch_way;
    logic [WAY_WIDTH-1:0] touch_age;

    assign touch_way = hit ? hit_way : victim_way;  // a filled victim becomes newest
    assign touch_age = age[req_addr][touch_way];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SET_NUM; s++) begin
                for (int w = 0; w < WAY_NUM; w++) begin
                    age[s][w] <= WAY_WIDTH'(w);  // start as a permutation
                end
            end
        end else if (lru_touch) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (WAY_WIDTH'(w) == touch_way) begin
                    age[req_addr][w] <= WAY_WIDTH'(WAY_NUM - 1);
                end else if (age[req_addr][w] > touch_age) begin
                    age[req_addr][w] <= age[req_addr][w] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        victim_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (age[req_addr][w] == '0) begin
                victim_way = WAY_WIDTH'(w);
            end
        end
    end

    function automatic logic ages_distinct(input logic [INDEX_WIDTH-1:0] s);
        logic [WAY_NUM-1:0] seen;
        seen = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            seen[age[s][w]] = 1'b1;
        end
        return &seen;
    endfunction

    // every age value appears once per set, so exactly one victim exists
    a_ages_permutation: assert property (
        @(posedge clk) disable iff (!rstn)
        lru_touch |=> ages_distinct($past(req_addr))
    );

endmodule

//--- verilog/cache_ways.sv
module cache_ways import cache_pkg::*; #(
    parameter int  INDEX_WIDTH       = 3,
    parameter int  WORD_OFFSET_WIDTH = 2,
    parameter int  WAY_NUM           = 2,
    localparam int LINE_WIDTH        = WORD_WIDTH << WORD_OFFSET_WIDTH,
    localparam int WAY_WIDTH         = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [ADDR_WIDTH-1:0] addr,          // live cpu address, read index
    input  logic [ADDR_WIDTH-1:0] req_addr,      // buffered address, write index and tag
    input  logic                  array_we,
    input  logic                  op_write,
    input  logic [LINE_WIDTH-1:0] wr_line,
    input  logic [WAY_WIDTH-1:0]  victim_way,
    output logic                  hit,
    output logic [WAY_WIDTH-1:0]  hit_way,
    output logic                  victim_dirty,
    output logic [LINE_WIDTH-1:0] sel_line,
    output logic [ADDR_WIDTH-1:0] victim_addr
);

    localparam int INDEX_LSB = WORD_OFFSET_WIDTH + BYTE_OFFSET_WIDTH;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_WIDTH;
    localparam int TAG_WIDTH = ADDR_WIDTH - TAG_LSB;
    localparam int SET_NUM   = 1 << INDEX_WIDTH;

    typedef struct packed {
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef logic [LINE_WIDTH-1:0] line_t;

    logic [INDEX_WIDTH-1:0] r_index;
    logic [INDEX_WIDTH-1:0] w_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    tag_entry_t             wr_entry;
    tag_entry_t             rd_entry [WAY_NUM];
    line_t                  rd_line  [WAY_NUM];
    logic [WAY_NUM-1:0]     way_valid;
    logic [WAY_NUM-1:0]     way_hit;
    logic [WAY_NUM-1:0]     way_we;
    logic [WAY_WIDTH-1:0]   sel_way;

    assign r_index  = addr[TAG_LSB-1:INDEX_LSB];
    assign w_index  = req_addr[TAG_LSB-1:INDEX_LSB];
    assign req_tag  = req_addr[ADDR_WIDTH-1:TAG_LSB];
    assign wr_entry = '{dirty: op_write, tag: req_tag};

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        logic [SET_NUM-1:0] valid_q;  // kept out of the ram so reset can clear it

        line_ram #(.INDEX_WIDTH(INDEX_WIDTH), .payload_t(tag_entry_t)) u_tag_ram (
            .clk(clk), .raddr(r_index), .waddr(w_index),
            .we(way_we[w]), .din(wr_entry), .dout(rd_entry[w])
        );

        line_ram #(.INDEX_WIDTH(INDEX_WIDTH), .payload_t(line_t)) u_data_ram (
            .clk(clk), .raddr(r_index), .waddr(w_index),
            .we(way_we[w]), .din(wr_line), .dout(rd_line[w])
        );

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= '0;
            end else if (way_we[w]) begin
                valid_q[w_index] <= 1'b1;
            end
        end

        assign way_valid[w] = valid_q[w_index];
        assign way_hit[w]   = way_valid[w] && (rd_entry[w].tag == req_tag);
        assign way_we[w]    = array_we && (sel_way == WAY_WIDTH'(w));
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (way_hit[w]) begin
                hit_way = WAY_WIDTH'(w);
            end
        end
    end

    assign hit     = |way_hit;
    assign sel_way = hit ? hit_way : victim_way;  // fills land in the victim way
    assign sel_line = rd_line[sel_way];

    assign victim_dirty = way_valid[victim_way] && rd_entry[victim_way].dirty;
    assign victim_addr  = {rd_entry[victim_way].tag, w_index, {INDEX_LSB{1'b0}}};

endmodule

//--- verilog/line_ram.sv
module line_ram #(
    parameter int  INDEX_WIDTH = 3,
    parameter type payload_t   = logic [31:0]
) (
    input  logic                   clk,
    input  logic [INDEX_WIDTH-1:0] raddr,  // data shows up one cycle later
    input  logic [INDEX_WIDTH-1:0] waddr,
    input  logic                   we,
    input  payload_t               din,
    output payload_t               dout
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        dout <= mem[raddr];  // old data on a same-index collision
    end

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_WIDTH        = 32;  // cpu and memory byte address
    localparam int WORD_WIDTH        = 32;  // one cpu data word
    localparam int BYTE_OFFSET_WIDTH = 2;   // accesses are always whole words

    // controller states, also used to qualify datapath muxes
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,  // waiting for r_req or w_req
        ST_LOOKUP = 3'd1,  // tag compare, hits complete here
        ST_EVICT  = 3'd2,  // dirty victim write-back in flight
        ST_FETCH  = 3'd3,  // line read from memory
        ST_REFILL = 3'd4   // returned line goes into the arrays
    } cache_state_t;

endpackage
